//--- source/board_map_pkg.sv
// ----------------------------------------------------------------------
// register map of the board register block
// offsets decode address bits 3:0, the space code bits 15:12
// status-write bit positions assume a 4-axis board (bits 7:4, 15:12 unused)
// ----------------------------------------------------------------------
package board_map_pkg;

    // address space
    localparam logic [3:0] ADDR_MAIN = 4'h0;   // main board space

    // register offsets
    localparam logic [3:0] REG_STATUS  = 4'h0;
    localparam logic [3:0] REG_WDOG    = 4'h3; // watchdog period, in ticks
    localparam logic [3:0] REG_VERSION = 4'h4;
    localparam logic [3:0] REG_TEMPSNS = 4'h5;
    localparam logic [3:0] REG_DIGIOUT = 4'h6;
    localparam logic [3:0] REG_DIGIN   = 4'ha;
    localparam logic [3:0] REG_DSSTAT  = 4'hd; // one-wire chip status

    // ------------------------------------------------------------------
    // status write fields, each value bit applies only with its mask bit
    // ------------------------------------------------------------------
    localparam int AMP_EN_LSB     = 0;     // amplifier enables
    localparam int AMP_MASK_LSB   = 8;     // amplifier enable masks
    localparam int RELAY_VAL_BIT  = 16;
    localparam int RELAY_MASK_BIT = 17;
    localparam int PWR_VAL_BIT    = 18;
    localparam int PWR_MASK_BIT   = 19;

    // unmasked command bits, one pulse each
    localparam int DAC_RETEST_BIT     = 22;
    localparam int IOEXP_REDETECT_BIT = 23;
    localparam int DOUT_CFG_RST_BIT   = 24;

    // status read word
    localparam int STATUS_WDOG_BIT = 23;   // host software expects the flag here

endpackage

//--- source/board_io_pkg.sv
// ----------------------------------------------------------------------
// signal types of the board register block
// axis vectors are indexed from 0, axis 1 of the board is bit 0
// ----------------------------------------------------------------------
package board_io_pkg;

    localparam int NUM_AXES    = 4;    // amplifier axes on the board
    localparam int REG_ADDR_W  = 16;
    localparam int REG_WORD_W  = 32;
    localparam int WDOG_PER_W  = 16;

    typedef logic [NUM_AXES-1:0]   axis_vec_t;     // one bit per axis
    typedef logic [REG_ADDR_W-1:0] reg_addr_t;     // register address
    typedef logic [REG_WORD_W-1:0] reg_word_t;     // register data word
    typedef logic [WDOG_PER_W-1:0] wdog_period_t;  // watchdog period in ticks

endpackage

//--- source/board_regs.sv
// ----------------------------------------------------------------------
// board register port: main-space writes and read-back mux
// read data shows up one clock after the address, writes hold it
// axis enables are refused unless power was already on
// ----------------------------------------------------------------------
`timescale 1ns/1ps

module board_regs #(
    parameter logic [3:0]  NUM_CHAN = 4'd4,
    parameter logic [31:0] VERSION  = 32'h514C4131   // "QLA1"
) (
    input  logic                       sysclk,
    input  logic                       rst_n,
    // register port
    input  board_io_pkg::reg_addr_t    reg_raddr,
    input  board_io_pkg::reg_addr_t    reg_waddr,
    input  board_io_pkg::reg_word_t    reg_wdata,
    input  logic                       reg_wen,
    output board_io_pkg::reg_word_t    reg_rdata,
    // board inputs
    input  board_io_pkg::reg_word_t    dout,
    input  board_io_pkg::reg_word_t    ds_status,
    input  logic                       dout_cfg_valid,
    input  logic                       dout_cfg_bidir,
    input  logic                       is_quad_dac,
    input  logic                       ioexp_present,
    input  board_io_pkg::axis_vec_t    enc_a,
    input  board_io_pkg::axis_vec_t    enc_b,
    input  board_io_pkg::axis_vec_t    enc_i,
    input  board_io_pkg::axis_vec_t    neg_limit,
    input  board_io_pkg::axis_vec_t    pos_limit,
    input  board_io_pkg::axis_vec_t    home,
    input  board_io_pkg::axis_vec_t    fault,       // 1 = amplifier ok
    input  logic                       relay,
    input  logic                       mv_faultn,
    input  logic                       mv_good,
    input  logic                       v_fault,
    input  logic                       safety_fb,
    input  logic                       mv_fb,
    input  logic [3:0]                 board_id,
    input  logic [15:0]                temp_sense,
    // from the datapath blocks
    input  board_io_pkg::axis_vec_t    settle_disable,
    input  board_io_pkg::axis_vec_t    safety_amp_disable,
    input  logic                       wdog_timeout,
    // board controls
    output board_io_pkg::axis_vec_t    amp_disable,
    output logic                       pwr_enable,
    output logic                       relay_on,
    output logic                       dac_test_reset,
    output logic                       ioexp_cfg_reset,
    output logic                       dout_cfg_reset,
    output logic                       pwr_enable_cmd,
    output board_io_pkg::axis_vec_t    amp_enable_cmd,
    output logic                       wdog_clear,
    output logic                       wdog_pet,
    output logic                       wdog_period_wr,
    output board_io_pkg::wdog_period_t wdog_period
);
    import board_map_pkg::*;
    import board_io_pkg::*;

    logic      write_main;
    logic      write_status;
    logic      write_wdog;
    axis_vec_t amp_en;           // enable value field
    axis_vec_t amp_mask;         // enable mask field
    axis_vec_t reg_disable;      // host-side disables, 1 = off
    reg_word_t reg_status;
    reg_word_t reg_digin;

    // ------------------------------------------------------------------
    // write decode
    // ------------------------------------------------------------------
    assign write_main   = reg_wen && (reg_waddr[15:12] == ADDR_MAIN) && (reg_waddr[7:4] == 4'd0);
    assign write_status = write_main && (reg_waddr[3:0] == REG_STATUS);
    assign write_wdog   = write_main && (reg_waddr[3:0] == REG_WDOG);

    assign amp_en   = reg_wdata[AMP_EN_LSB +: NUM_AXES];
    assign amp_mask = reg_wdata[AMP_MASK_LSB +: NUM_AXES];

    // host asking for power or amplifiers, clears the error flags
    assign pwr_enable_cmd = write_status & reg_wdata[PWR_MASK_BIT] & reg_wdata[PWR_VAL_BIT];
    assign amp_enable_cmd = write_status ? (amp_en & amp_mask) : '0;
    assign wdog_clear     = pwr_enable_cmd | (|amp_enable_cmd);
    assign wdog_pet       = write_main;                 // any main write means host alive

    assign amp_disable = reg_disable | settle_disable;  // settle hold-off on top

    // ------------------------------------------------------------------
    // read words
    // ------------------------------------------------------------------
    always_comb begin
        reg_status        = '0;
        reg_status[31:28] = NUM_CHAN;
        reg_status[27:24] = board_id;
        reg_status[STATUS_WDOG_BIT] = wdog_timeout;
        reg_status[22]    = is_quad_dac;
        reg_status[21]    = dout_cfg_valid;
        reg_status[20]    = dout_cfg_bidir;
        reg_status[19]    = mv_good;
        reg_status[18]    = pwr_enable;
        reg_status[17]    = ~relay;            // relay feedback is active low
        reg_status[16]    = relay_on;
        reg_status[15]    = ~mv_faultn;
        reg_status[14]    = safety_fb;
        reg_status[12]    = ioexp_present;
        reg_status[11:8]  = fault;
        reg_status[7:4]   = safety_amp_disable;
        reg_status[3:0]   = ~reg_disable;      // 1 = enabled
    end

    // dout[31] flags the waveform table driving an output
    assign reg_digin = {v_fault, 1'b0, dout[31], mv_fb, enc_a, enc_b, enc_i,
                        dout[3:0], neg_limit, pos_limit, home};

    // ------------------------------------------------------------------
    // register file
    // ------------------------------------------------------------------
    always_ff @(posedge sysclk) begin
        if (!rst_n) begin
            reg_disable     <= '1;             // all axes off
            pwr_enable      <= 1'b0;
            relay_on        <= 1'b0;
            dac_test_reset  <= 1'b0;
            ioexp_cfg_reset <= 1'b0;
            dout_cfg_reset  <= 1'b0;
            wdog_period_wr  <= 1'b0;
            wdog_period     <= '0;             // watchdog off
            reg_rdata       <= '0;
        end else begin
            // pulses last one cycle
            dac_test_reset  <= 1'b0;
            ioexp_cfg_reset <= 1'b0;
            dout_cfg_reset  <= 1'b0;
            wdog_period_wr  <= 1'b0;
            if (reg_wen) begin
                if (write_status) begin
                    // masked enables, refused while power is still off
                    reg_disable <= {NUM_AXES{~pwr_enable}} | (amp_mask & ~amp_en)
                                   | (~amp_mask & reg_disable);
                    if (reg_wdata[RELAY_MASK_BIT])
                        relay_on <= reg_wdata[RELAY_VAL_BIT];
                    if (reg_wdata[PWR_MASK_BIT])
                        pwr_enable <= reg_wdata[PWR_VAL_BIT];
                    dac_test_reset  <= reg_wdata[DAC_RETEST_BIT];
                    ioexp_cfg_reset <= reg_wdata[IOEXP_REDETECT_BIT];
                    dout_cfg_reset  <= reg_wdata[DOUT_CFG_RST_BIT];
                end
                if (write_wdog) begin
                    wdog_period    <= reg_wdata[WDOG_PER_W-1:0];
                    wdog_period_wr <= 1'b1;    // reloads the watchdog next cycle
                end
            end else begin
                unique case (reg_raddr[3:0])
                    REG_STATUS:  reg_rdata <= reg_status;
                    REG_VERSION: reg_rdata <= VERSION;
                    REG_TEMPSNS: reg_rdata <= reg_word_t'(temp_sense);
                    REG_DIGIOUT: reg_rdata <= dout;
                    REG_DSSTAT:  reg_rdata <= ds_status;
                    REG_DIGIN:   reg_rdata <= reg_digin;
                    REG_WDOG:    reg_rdata <= reg_word_t'(wdog_period);
                    default:     reg_rdata <= '0;
                endcase
                // timeout drops every axis, otherwise only tripped ones
                reg_disable <= reg_disable | (wdog_timeout ? '1 : safety_amp_disable);
            end
        end
    end

    // a command pulse always follows a status write
    a_pulse_after_status: assert property (@(posedge sysclk) disable iff (!rst_n)
        (dac_test_reset | ioexp_cfg_reset | dout_cfg_reset) |-> $past(write_status));

endmodule

//--- source/mv_good_settle.sv
// ----------------------------------------------------------------------
// motor voltage settle delay
// axes are held off until mv_good stayed high SETTLE_CYCLES+1 clocks
// any drop of mv_good restarts the delay
// ----------------------------------------------------------------------
`timescale 1ns/1ps

module mv_good_settle #(
    parameter int SETTLE_CYCLES = 1966080   // about 40 ms at 49.152 MHz
) (
    input  logic                    sysclk,
    input  logic                    rst_n,
    input  logic                    mv_good,
    output board_io_pkg::axis_vec_t settle_disable
);
    localparam int CNT_W = $clog2(SETTLE_CYCLES + 1);

    logic [CNT_W-1:0] settle_cnt;           // clocks with voltage good

    always_ff @(posedge sysclk) begin
        if (!rst_n) begin
            settle_cnt     <= '0;
            settle_disable <= '1;
        end else if (!mv_good) begin
            settle_cnt     <= '0;           // restart on any drop
            settle_disable <= '1;
        end else if (settle_cnt < CNT_W'(SETTLE_CYCLES)) begin
            settle_cnt     <= settle_cnt + 1'b1;
            settle_disable <= '1;           // still settling
        end else begin
            settle_disable <= '0;
        end
    end

    a_off_after_drop: assert property (@(posedge sysclk) disable iff (!rst_n)
        !$past(mv_good) |-> (settle_disable == '1));

endmodule

//--- source/host_wdog.sv
// ----------------------------------------------------------------------
// host watchdog
// period counts ticks of WDOG_TICK_CYCLES clocks (at least 2)
// a period of 0 disables it, timeout accuracy is one tick
// ----------------------------------------------------------------------
`timescale 1ns/1ps

module host_wdog #(
    parameter int WDOG_TICK_CYCLES = 256
) (
    input  logic                       sysclk,
    input  logic                       rst_n,
    input  logic                       wdog_pet,        // host wrote something
    input  logic                       wdog_period_wr,  // new period stored
    input  board_io_pkg::wdog_period_t wdog_period,
    input  logic                       wdog_clear,
    output logic                       wdog_timeout
);
    localparam int TICK_W = $clog2(WDOG_TICK_CYCLES);

    logic [TICK_W-1:0]          pre_cnt;
    logic                       tick;
    board_io_pkg::wdog_period_t wdog_cnt;   // ticks left before timeout
    logic                       reload;

    assign tick   = (pre_cnt == TICK_W'(WDOG_TICK_CYCLES - 1));
    assign reload = wdog_pet | wdog_period_wr;

    // ------------------------------------------------------------------
    // tick prescaler, free running
    // ------------------------------------------------------------------
    always_ff @(posedge sysclk) begin
        if (!rst_n)
            pre_cnt <= '0;
        else
            pre_cnt <= tick ? '0 : pre_cnt + 1'b1;
    end

    // ------------------------------------------------------------------
    // down-counter and sticky flag
    // ------------------------------------------------------------------
    always_ff @(posedge sysclk) begin
        if (!rst_n) begin
            wdog_cnt     <= '0;
            wdog_timeout <= 1'b0;
        end else begin
            if (reload)
                wdog_cnt <= wdog_period;
            else if (tick && (wdog_cnt != '0))
                wdog_cnt <= wdog_cnt - 1'b1;

            if (wdog_clear)
                wdog_timeout <= 1'b0;       // host re-enabled power or an axis
            else if (!reload && tick && (wdog_cnt == 1))
                wdog_timeout <= 1'b1;       // last tick ran out
        end
    end

    a_no_trip_when_off: assert property (@(posedge sysclk) disable iff (!rst_n)
        $rose(wdog_timeout) |-> ($past(wdog_period) != '0));

endmodule

//--- source/amp_fault_latch.sv
// ----------------------------------------------------------------------
// per-axis amplifier safety latch
// fault inputs are active low, a trip needs the axis to be enabled
// ----------------------------------------------------------------------
`timescale 1ns/1ps

module amp_fault_latch (
    input  logic                    sysclk,
    input  logic                    rst_n,
    input  board_io_pkg::axis_vec_t fault,          // 0 = amplifier fault
    input  board_io_pkg::axis_vec_t amp_disable,
    input  logic                    pwr_enable_cmd,
    input  board_io_pkg::axis_vec_t amp_enable_cmd,
    output board_io_pkg::axis_vec_t safety_amp_disable
);
    import board_io_pkg::*;

    axis_vec_t trip;
    axis_vec_t clear;

    assign trip  = ~fault & ~amp_disable;                   // faulting while driven
    assign clear = amp_enable_cmd | {NUM_AXES{pwr_enable_cmd}};

    always_ff @(posedge sysclk) begin
        if (!rst_n)
            safety_amp_disable <= '0;
        else
            safety_amp_disable <= (safety_amp_disable & ~clear) | trip;  // trip wins
    end

endmodule

//--- source/board_ctrl_top.sv
// ----------------------------------------------------------------------
// board control top: register block plus settle, watchdog and latch
// all ports are single-clock on sysclk, reset is synchronous
// ----------------------------------------------------------------------
`timescale 1ns/1ps

module board_ctrl_top #(
    parameter logic [3:0]  NUM_CHAN         = 4'd4,
    parameter logic [31:0] VERSION          = 32'h514C4131,
    parameter int          SETTLE_CYCLES    = 1966080,
    parameter int          WDOG_TICK_CYCLES = 256
) (
    input  logic                    sysclk,
    input  logic                    rst_n,
    input  board_io_pkg::reg_addr_t reg_raddr,
    input  board_io_pkg::reg_addr_t reg_waddr,
    input  board_io_pkg::reg_word_t reg_wdata,
    input  logic                    reg_wen,
    output board_io_pkg::reg_word_t reg_rdata,
    input  board_io_pkg::reg_word_t dout,
    input  board_io_pkg::reg_word_t ds_status,
    input  logic                    dout_cfg_valid,
    input  logic                    dout_cfg_bidir,
    input  logic                    is_quad_dac,
    input  logic                    ioexp_present,
    input  board_io_pkg::axis_vec_t enc_a,
    input  board_io_pkg::axis_vec_t enc_b,
    input  board_io_pkg::axis_vec_t enc_i,
    input  board_io_pkg::axis_vec_t neg_limit,
    input  board_io_pkg::axis_vec_t pos_limit,
    input  board_io_pkg::axis_vec_t home,
    input  board_io_pkg::axis_vec_t fault,
    input  logic                    relay,
    input  logic                    mv_faultn,
    input  logic                    mv_good,
    input  logic                    v_fault,
    input  logic                    safety_fb,
    input  logic                    mv_fb,
    input  logic [3:0]              board_id,
    input  logic [15:0]             temp_sense,
    output board_io_pkg::axis_vec_t amp_disable,
    output logic                    pwr_enable,
    output logic                    relay_on,
    output logic                    dac_test_reset,
    output logic                    ioexp_cfg_reset,
    output logic                    dout_cfg_reset,
    output logic                    pwr_enable_cmd,
    output board_io_pkg::axis_vec_t amp_enable_cmd,
    output logic                    wdog_timeout
);
    import board_io_pkg::*;

    axis_vec_t    settle_disable;       // settle hold-off
    axis_vec_t    safety_amp_disable;   // tripped axes
    logic         wdog_clear;
    logic         wdog_pet;
    logic         wdog_period_wr;
    wdog_period_t wdog_period;

    board_regs #(
        .NUM_CHAN (NUM_CHAN),
        .VERSION  (VERSION)
    ) regs_i (
        .sysclk, .rst_n,
        .reg_raddr, .reg_waddr, .reg_wdata, .reg_wen, .reg_rdata,
        .dout, .ds_status, .dout_cfg_valid, .dout_cfg_bidir,
        .is_quad_dac, .ioexp_present,
        .enc_a, .enc_b, .enc_i, .neg_limit, .pos_limit, .home, .fault,
        .relay, .mv_faultn, .mv_good, .v_fault, .safety_fb, .mv_fb,
        .board_id, .temp_sense,
        .settle_disable, .safety_amp_disable, .wdog_timeout,
        .amp_disable, .pwr_enable, .relay_on,
        .dac_test_reset, .ioexp_cfg_reset, .dout_cfg_reset,
        .pwr_enable_cmd, .amp_enable_cmd,
        .wdog_clear, .wdog_pet, .wdog_period_wr, .wdog_period
    );

    mv_good_settle #(
        .SETTLE_CYCLES (SETTLE_CYCLES)
    ) settle_i (
        .sysclk, .rst_n, .mv_good, .settle_disable
    );

    host_wdog #(
        .WDOG_TICK_CYCLES (WDOG_TICK_CYCLES)
    ) wdog_i (
        .sysclk, .rst_n,
        .wdog_pet, .wdog_period_wr, .wdog_period, .wdog_clear,
        .wdog_timeout
    );

    amp_fault_latch latch_i (
        .sysclk, .rst_n,
        .fault, .amp_disable, .pwr_enable_cmd, .amp_enable_cmd,
        .safety_amp_disable
    );

endmodule

//--- tb/board_ctrl_tb.sv
// ----------------------------------------------------------------------
// testbench of the board register block, table driven
// inputs change on the rising edge, outputs are checked on the falling edge
// wdog period and settle length assume WDOG_TICK_CYCLES 8, SETTLE_CYCLES 64
// ----------------------------------------------------------------------
`timescale 1ns/1ps

module board_ctrl_tb;
    import board_io_pkg::*;
    import board_map_pkg::*;

    localparam logic [31:0] VER  = 32'h514C4131;
    localparam int K_RD = 0, K_WR = 1, K_IDLE = 2, K_SET = 3, K_PULSE = 4, K_WDOG = 5;
    localparam int MAX_T = 48;

    logic sysclk, rst_n, reg_wen;
    reg_addr_t reg_raddr, reg_waddr;
    reg_word_t reg_wdata, reg_rdata, dout, ds_status;
    logic dout_cfg_valid, dout_cfg_bidir, is_quad_dac, ioexp_present;
    axis_vec_t enc_a, enc_b, enc_i, neg_limit, pos_limit, home, fault;
    logic relay, mv_faultn, mv_good, v_fault, safety_fb, mv_fb;
    logic [3:0] board_id;
    logic [15:0] temp_sense;
    axis_vec_t amp_disable, amp_enable_cmd;
    logic pwr_enable, relay_on, dac_test_reset, ioexp_cfg_reset, dout_cfg_reset;
    logic pwr_enable_cmd, wdog_timeout;

    // stimulus table
    int        t_kind [MAX_T];
    reg_addr_t t_addr [MAX_T];
    reg_word_t t_data [MAX_T];
    logic      t_mvg  [MAX_T];
    axis_vec_t t_flt  [MAX_T];
    reg_word_t t_exp  [MAX_T];
    reg_word_t t_mask [MAX_T];   // word mask, or output flag mask
    axis_vec_t t_dis  [MAX_T];
    logic      t_dchk [MAX_T];   // check amp_disable
    int        t_cyc  [MAX_T];
    int        n_tests = 0;
    logic      table_ready = 1'b0;
    int        errors = 0;
    int        checks = 0;
    int        seed = 32'h2b1d633c;
    logic      wr_pwr_cmd;       // pwr_enable_cmd seen in the write cycle
    axis_vec_t wr_amp_cmd;       // amp_enable_cmd seen in the write cycle

    board_ctrl_top #(
        .NUM_CHAN (4'd4), .VERSION (VER),
        .SETTLE_CYCLES (64), .WDOG_TICK_CYCLES (8)
    ) dut_i (.*);

    initial begin
        sysclk = 1'b0;
        forever #20 sysclk = ~sysclk;
    end

    // -------------------------------------------------------------------
    // compare tasks
    // -------------------------------------------------------------------
    task automatic cmp_word(input reg_word_t got, input reg_word_t exp,
                            input reg_word_t mask, input string what);
        checks++;
        if ((got & mask) !== (exp & mask)) begin
            errors++;
            $display("MISMATCH at %0t: %s got %h expected %h (mask %h)",
                     $time, what, got, exp, mask);
        end
    endtask

    task automatic cmp_axes(input axis_vec_t got, input axis_vec_t exp, input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("MISMATCH at %0t: %s got %b expected %b", $time, what, got, exp);
        end
    endtask

    task automatic cmp_bit(input logic got, input logic exp, input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("MISMATCH at %0t: %s got %b expected %b", $time, what, got, exp);
        end
    endtask

    // flag bits pwr, relay, dac, ioexp and dout pulse, write-cycle pwr command, wdog flag
    // mask bit 8 checks the write-cycle amp command against expected bits 11:8
    task automatic check_outs(input int i);
        string names [7];
        logic  vals [7];
        names = '{"pwr_enable", "relay_on", "dac_test_reset", "ioexp_cfg_reset",
                  "dout_cfg_reset", "pwr_enable_cmd", "wdog_timeout"};
        vals = '{pwr_enable, relay_on, dac_test_reset, ioexp_cfg_reset, dout_cfg_reset,
                 wr_pwr_cmd, wdog_timeout};
        for (int b = 0; b < 7; b++)
            if (t_mask[i][b])
                cmp_bit(vals[b], t_exp[i][b], names[b]);
        if (t_mask[i][8])
            cmp_axes(wr_amp_cmd, t_exp[i][11:8], "amp_enable_cmd");
        if (t_dchk[i])
            cmp_axes(amp_disable, t_dis[i], "amp_disable");
    endtask

    task automatic add(input int k, input reg_addr_t a, input reg_word_t d, input logic mvg,
                       input axis_vec_t flt, input reg_word_t e, input reg_word_t m,
                       input axis_vec_t dis, input logic dchk, input int cyc);
        t_kind[n_tests] = k;
        t_addr[n_tests] = a;
        t_data[n_tests] = d;
        t_mvg[n_tests]  = mvg;
        t_flt[n_tests]  = flt;
        t_exp[n_tests]  = e;
        t_mask[n_tests] = m;
        t_dis[n_tests]  = dis;
        t_dchk[n_tests] = dchk;
        t_cyc[n_tests]  = cyc;
        n_tests++;
    endtask

    task automatic do_write(input reg_addr_t a, input reg_word_t d);
        @(posedge sysclk);
        reg_wen   <= 1'b1;
        reg_waddr <= a;
        reg_wdata <= d;
        @(negedge sysclk);                     // commands are combinational here
        wr_pwr_cmd = pwr_enable_cmd;
        wr_amp_cmd = amp_enable_cmd;
        @(posedge sysclk);                     // DUT takes the write here
        reg_wen   <= 1'b0;
        @(negedge sysclk);
    endtask

    // -------------------------------------------------------------------
    // table of tests
    // -------------------------------------------------------------------
    task automatic build_table();
        reg_word_t digin;
        digin = {4'h0, enc_a, enc_b, enc_i, dout[3:0], neg_limit, pos_limit, home};
        // after reset
        add(K_IDLE, 0, 0, 0, '1, 0, 32'h5f, 4'hf, 1, 1);
        add(K_RD, 16'h0004, 0, 0, '1, VER, '1, 0, 0, 0);
        add(K_RD, 16'h0000, 0, 0, '1, {4'd4, board_id, 24'h0}, 32'hff000000, 0, 0, 0);
        // masked writes
        add(K_WR, 16'h0000, 32'h00040000, 0, '1, 0, 32'h21, 0, 0, 0);
        add(K_SET, 0, 0, 1, '1, 0, 0, 0, 0, 0);
        add(K_WR, 16'h0000, 32'h00000f0f, 1, '1, 32'hf00, 32'h100, 0, 0, 0);   // no power yet
        add(K_IDLE, 0, 0, 1, '1, 0, 0, 4'hf, 1, 70);
        add(K_WR, 16'h0000, 32'h000c0000, 1, '1, 32'h21, 32'h23, 0, 0, 0);
        add(K_WR, 16'h0000, 32'h00030000, 1, '1, 32'h3, 32'h3, 0, 0, 0);
        add(K_RD, 16'h0000, 0, 1, '1, 32'h00050000, 32'h00050000, 0, 0, 0);
        // settle delay
        add(K_SET, 0, 0, 0, '1, 0, 0, 0, 0, 0);
        add(K_SET, 0, 0, 1, '1, 0, 0, 0, 0, 0);
        add(K_WR, 16'h0000, 32'h00000f0f, 1, '1, 0, 0, 0, 0, 0);
        add(K_IDLE, 0, 0, 1, '1, 0, 0, 4'hf, 1, 55);
        add(K_IDLE, 0, 0, 1, '1, 0, 0, 4'h0, 1, 15);
        add(K_SET, 0, 0, 0, '1, 0, 0, 0, 0, 0);
        add(K_IDLE, 0, 0, 0, '1, 0, 0, 4'hf, 1, 1);
        add(K_SET, 0, 0, 1, '1, 0, 0, 0, 0, 0);
        add(K_IDLE, 0, 0, 1, '1, 0, 0, 4'h0, 1, 70);
        // command pulses, power and relay stay on
        add(K_PULSE, 16'h0000, 32'h1 << DAC_RETEST_BIT, 1, '1, 32'h07, 32'h1f, 0, 0, 0);
        add(K_PULSE, 16'h0000, 32'h1 << IOEXP_REDETECT_BIT, 1, '1, 32'h0b, 32'h1f, 0, 0, 0);
        add(K_PULSE, 16'h0000, 32'h1 << DOUT_CFG_RST_BIT, 1, '1, 32'h13, 32'h1f, 0, 0, 0);
        // safety latch on axis 1
        add(K_SET, 0, 0, 1, 4'b1101, 0, 0, 0, 0, 0);
        add(K_IDLE, 0, 0, 1, 4'b1101, 0, 0, 4'b0010, 1, 3);
        add(K_SET, 0, 0, 1, 4'hf, 0, 0, 0, 0, 0);
        add(K_IDLE, 0, 0, 1, 4'hf, 0, 0, 4'b0010, 1, 3);
        add(K_WR, 16'h0000, 32'h00000202, 1, '1, 32'h200, 32'h100, 0, 0, 0);
        add(K_IDLE, 0, 0, 1, 4'hf, 0, 0, 4'h0, 1, 3);
        // host watchdog, period 20 ticks
        add(K_WDOG, 16'h0003, 32'd20, 1, '1, 0, 0, 0, 0, 0);
        add(K_IDLE, 0, 0, 1, '1, 32'h40, 32'h40, 4'hf, 1, 2);
        add(K_WR, 16'h0000, 32'h000c0000, 1, '1, 32'h21, 32'h61, 0, 0, 0);
        add(K_RD, 16'h0000, 0, 1, '1, 0, 32'h1 << STATUS_WDOG_BIT, 0, 0, 0);
        add(K_WR, 16'h0003, 32'd0, 1, '1, 0, 0, 0, 0, 0);
        // read mux
        add(K_RD, 16'h0005, 0, 1, '1, {16'h0, temp_sense}, '1, 0, 0, 0);
        add(K_RD, 16'h0006, 0, 1, '1, dout, '1, 0, 0, 0);
        add(K_RD, 16'h000d, 0, 1, '1, ds_status, '1, 0, 0, 0);
        add(K_RD, 16'h000a, 0, 1, '1, digin, 32'h0fffffff, 0, 0, 0);
        add(K_RD, 16'h0009, 0, 1, '1, 0, '1, 0, 0, 0);
    endtask

    task automatic run_test(input int i);
        int cnt;
        int lim;
        case (t_kind[i])
            K_RD: begin
                @(posedge sysclk);
                reg_raddr <= t_addr[i];
                reg_wen   <= 1'b0;
                @(posedge sysclk);
                @(negedge sysclk);
                cmp_word(reg_rdata, t_exp[i], t_mask[i], "reg_rdata");
            end
            K_WR: begin
                do_write(t_addr[i], t_data[i]);
                check_outs(i);
            end
            K_IDLE: begin
                repeat (t_cyc[i]) begin
                    @(posedge sysclk);
                    reg_wen <= 1'b0;
                end
                @(negedge sysclk);
                check_outs(i);
            end
            K_SET: begin
                @(posedge sysclk);
                mv_good <= t_mvg[i];
                fault   <= t_flt[i];
            end
            K_PULSE: begin
                do_write(t_addr[i], t_data[i]);
                check_outs(i);                 // pulse cycle
                @(posedge sysclk);
                @(negedge sysclk);
                cmp_word({27'h0, dout_cfg_reset, ioexp_cfg_reset, dac_test_reset, 2'b00},
                         0, 32'h1c, "pulses after one cycle");
            end
            K_WDOG: begin
                @(posedge sysclk);
                reg_raddr <= 16'h0000;         // poll status while waiting
                do_write(t_addr[i], t_data[i]);
                cnt = 0;
                lim = t_data[i] * 8 + 40;
                while (!reg_rdata[STATUS_WDOG_BIT] && cnt < lim) begin
                    @(posedge sysclk);
                    @(negedge sysclk);
                    cnt++;
                end
                checks++;
                if (!reg_rdata[STATUS_WDOG_BIT]) begin
                    errors++;
                    $display("watchdog flag never set in status after %0d cycles", cnt);
                end else if (cnt < t_data[i] * 8 - 8 || cnt > t_data[i] * 8 + 9) begin
                    errors++;
                    $display("MISMATCH at %0t: watchdog fired after %0d cycles", $time, cnt);
                end
            end
            default: ;
        endcase
    endtask

    // -------------------------------------------------------------------
    // main sequence
    // -------------------------------------------------------------------
    initial begin
        int e0;
        rst_n     = 1'b0;
        reg_wen   = 1'b0;
        reg_raddr = '0;
        reg_waddr = '0;
        reg_wdata = '0;
        wr_pwr_cmd = 1'b0;
        wr_amp_cmd = '0;
        board_id   = $random(seed);
        temp_sense = $random(seed);
        dout       = $random(seed);
        ds_status  = $random(seed);
        dout_cfg_valid = 1'b0;
        dout_cfg_bidir = 1'b0;
        is_quad_dac    = 1'b1;
        ioexp_present  = 1'b0;
        enc_a     = 4'h5;
        enc_b     = 4'ha;
        enc_i     = 4'h3;
        neg_limit = 4'h9;
        pos_limit = 4'h6;
        home      = 4'hc;
        fault     = 4'hf;                      // all amplifiers ok
        relay     = 1'b1;
        mv_faultn = 1'b1;
        mv_good   = 1'b0;
        v_fault   = 1'b0;
        safety_fb = 1'b0;
        mv_fb     = 1'b0;
        build_table();
        table_ready = 1'b1;
        repeat (10) @(posedge sysclk);
        rst_n <= 1'b1;
        for (int i = 0; i < n_tests; i++) begin
            e0 = errors;
            run_test(i);
            $display("test %0d kind %0d: %s", i, t_kind[i], (errors == e0) ? "ok" : "failed");
        end
        $display("%0d tests, %0d checks, %0d errors", n_tests, checks, errors);
        if (errors == 0)
            $display("TESTS PASSED");
        else
            $display("TESTS FAILED");
        $finish;
    end

    // run limit, 200 cycles per table entry
    initial begin
        wait (table_ready);
        #(n_tests * 200 * 40);
        $display("run timed out before the table was finished");
        $display("TESTS FAILED");
        $finish;
    end

endmodule

//--- flist.f
source/board_map_pkg.sv
source/board_io_pkg.sv
source/board_regs.sv
source/mv_good_settle.sv
source/host_wdog.sv
source/amp_fault_latch.sv
source/board_ctrl_top.sv
tb/board_ctrl_tb.sv

//--- Bender.yml
package:
  name: board_ctrl

sources:
  - files:
      - source/board_map_pkg.sv
      - source/board_io_pkg.sv
      - source/board_regs.sv
      - source/mv_good_settle.sv
      - source/host_wdog.sv
      - source/amp_fault_latch.sv
      - source/board_ctrl_top.sv
  - target: test
    files:
      - tb/board_ctrl_tb.sv
